/* flist.f */
common/rv32i_types_pkg.sv
common/line_mem_if.sv
cache/i_cache.sv
cache/d_cache.sv
arbiter/arbiter.sv
source/cacheline_adaptor.sv
source/cache_sys.sv
tb/cache_sys_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= cache_sys_tb
RTL_TOP   ?= cache_sys
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 4
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -f $(FLIST)
	@out=$$(./$(BUILD_DIR)/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tb/cache_sys_tb.sv */
`timescale 1ns/1ps

module cache_sys_tb
	import rv32i_types_pkg::*;
();

	localparam int        n_tests = 16;
	localparam int        entry_limit = 150;
	localparam rv32i_word no_addr = '1;

	typedef enum logic [1:0] {p_instr, p_data, p_both} port_e;
	typedef enum logic {op_read, op_write} op_e;

	// iaddr is the fetch address when both ports run at once
	typedef struct packed {
		port_e      port;
		op_e        op;
		rv32i_word  addr;
		rv32i_word  iaddr;
		rv32i_word  wdata;
		logic [3:0] mbe;
		int         stall;
		rv32i_word  first_addr;
		logic       first_wr;
	} entry_t;

	logic       clk;
	logic       i_reset;
	burst_t     i_pmem_rdata;
	logic       i_pmem_resp;
	logic       o_pmem_read;
	logic       o_pmem_write;
	rv32i_word  o_pmem_address;
	burst_t     o_pmem_wdata;
	logic       i_instr_read;
	rv32i_word  i_instr_mem_address;
	logic       i_if_id_reg_load;
	rv32i_word  o_instr_mem_rdata;
	logic       o_instr_resp;
	logic       i_data_read;
	logic       i_data_write;
	rv32i_word  i_data_mem_address;
	logic [3:0] i_data_mbe;
	rv32i_word  i_data_mem_wdata;
	rv32i_word  o_data_mem_rdata;
	logic       o_data_resp;

	rv32i_word  mem_words [256];
	rv32i_word  shadow [256];
	entry_t     tests [n_tests];
	rv32i_word  seed = 32'h6fe5;
	int         mismatches = 0;
	int         failures = 0;
	logic       xfer_seen = 1'b0;
	rv32i_word  first_addr;
	logic       first_wr;

	cache_sys i_dut (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	function automatic rv32i_word next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int word_index(input rv32i_word a);
		return int'(a[9:2]);
	endfunction

	task automatic check_word(input string name, input rv32i_word got, input rv32i_word exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_burst(input string name, input burst_t got, input burst_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// burst memory answering each beat after 0 to 3 wait cycles
	initial begin : pmem_model
		rv32i_word base;
		rv32i_word r;
		logic      is_write;
		int        w;
		i_pmem_resp  = 1'b0;
		i_pmem_rdata = '0;
		for (int i = 0; i < 256; i++) begin
			mem_words[i] = next_rand() ^ (i << 2);
			shadow[i]    = mem_words[i];
		end
		forever begin
			@(posedge clk);
			#1;
			if (!i_reset && (o_pmem_read || o_pmem_write)) begin
				base     = o_pmem_address;
				is_write = o_pmem_write;
				if (!xfer_seen) begin
					xfer_seen  = 1'b1;
					first_addr = base;
					first_wr   = is_write;
				end
				for (int b = 0; b < bursts_per_line; b++) begin
					r = next_rand();
					repeat (r[17:16]) begin
						@(posedge clk);
						#1;
					end
					w = word_index(base) + 2 * b;
					if (is_write) begin
						// the evicted line must hold what the CPU wrote
						check_burst("o_pmem_wdata", o_pmem_wdata, {shadow[w + 1], shadow[w]});
						mem_words[w]     = o_pmem_wdata[31:0];
						mem_words[w + 1] = o_pmem_wdata[63:32];
					end else begin
						i_pmem_rdata = {mem_words[w + 1], mem_words[w]};
					end
					i_pmem_resp = 1'b1;
					@(posedge clk);
					#1;
					i_pmem_resp = 1'b0;
				end
			end
		end
	end

	task automatic run_entry(input entry_t e);
		int        cycles;
		int        stall_left;
		logic      i_wait;
		logic      d_wait;
		rv32i_word i_addr;
		rv32i_word held;
		cycles     = 0;
		stall_left = 0;
		held       = '0;
		i_addr     = (e.port == p_both) ? e.iaddr : e.addr;
		i_wait     = (e.port != p_data);
		d_wait     = (e.port != p_instr);
		xfer_seen  = 1'b0;
		if (i_wait) begin
			i_instr_read        = 1'b1;
			i_instr_mem_address = i_addr;
			i_if_id_reg_load    = (e.stall == 0);
		end
		if (d_wait) begin
			i_data_read        = (e.op == op_read);
			i_data_write       = (e.op == op_write);
			i_data_mem_address = e.addr;
			i_data_mbe         = e.mbe;
			i_data_mem_wdata   = e.wdata;
		end
		while (i_wait || d_wait || stall_left > 0) begin
			@(posedge clk);
			#1;
			cycles++;
			if (stall_left > 0) begin
				// while IF/ID is stalled the fetch word must not move or answer twice
				check_bit("o_instr_resp", o_instr_resp, 1'b0);
				check_word("o_instr_mem_rdata", o_instr_mem_rdata, held);
				stall_left--;
				if (stall_left == 0) begin
					i_instr_read     = 1'b0;
					i_if_id_reg_load = 1'b1;
				end
			end else if (i_wait && o_instr_resp) begin
				held = shadow[word_index(i_addr)];
				check_word("o_instr_mem_rdata", o_instr_mem_rdata, held);
				i_wait     = 1'b0;
				stall_left = e.stall;
				if (e.stall == 0) begin
					i_instr_read = 1'b0;
				end else begin
					// a parked fetch ignores a new address in the same line
					i_instr_mem_address = i_addr ^ 32'h4;
				end
			end
			if (d_wait && o_data_resp) begin
				if (e.op == op_read) begin
					check_word("o_data_mem_rdata", o_data_mem_rdata, shadow[word_index(e.addr)]);
				end else begin
					for (int k = 0; k < 4; k++) begin
						if (e.mbe[k]) begin
							shadow[word_index(e.addr)][k*8 +: 8] = e.wdata[k*8 +: 8];
						end
					end
				end
				i_data_read  = 1'b0;
				i_data_write = 1'b0;
				d_wait       = 1'b0;
			end
			if (cycles > entry_limit) begin
				failures++;
				$display("Error at %0t: request to %h got no response in %0d cycles",
					$time, e.addr, entry_limit);
				i_instr_read     = 1'b0;
				i_data_read      = 1'b0;
				i_data_write     = 1'b0;
				i_if_id_reg_load = 1'b1;
				i_wait           = 1'b0;
				d_wait           = 1'b0;
				stall_left       = 0;
			end
		end
		if (e.first_addr != no_addr) begin
			if (!xfer_seen) begin
				failures++;
				$display("Error at %0t: no memory transfer seen for %h", $time, e.addr);
			end else begin
				check_word("o_pmem_address", first_addr, e.first_addr);
				check_bit("o_pmem_write", first_wr, e.first_wr);
			end
		end
		@(posedge clk);
		#1;
	endtask

	initial begin : watchdog
		repeat (n_tests * 200 + 1000) @(posedge clk);
		$display("Error: watchdog expired before the tests finished");
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		i_reset             = 1'b1;
		i_instr_read        = 1'b0;
		i_instr_mem_address = '0;
		i_if_id_reg_load    = 1'b1;
		i_data_read         = 1'b0;
		i_data_write        = 1'b0;
		i_data_mem_address  = '0;
		i_data_mbe          = '0;
		i_data_mem_wdata    = '0;

		// fetch miss followed by stalled and plain hits in the same line
		tests[0]  = '{p_instr, op_read, 32'h040, 32'h0, 32'h0, 4'h0, 0, no_addr, 1'b0};
		tests[1]  = '{p_instr, op_read, 32'h044, 32'h0, 32'h0, 4'h0, 3, no_addr, 1'b0};
		tests[2]  = '{p_instr, op_read, 32'h048, 32'h0, 32'h0, 4'h0, 0, no_addr, 1'b0};
		// write miss and partial write hit with read back
		tests[3]  = '{p_data, op_write, 32'h0a0, 32'h0, 32'h11223344, 4'hf, 0, no_addr, 1'b0};
		tests[4]  = '{p_data, op_write, 32'h0a4, 32'h0, 32'haabbccdd, 4'h5, 0, no_addr, 1'b0};
		tests[5]  = '{p_data, op_read, 32'h0a0, 32'h0, 32'h0, 4'h0, 0, no_addr, 1'b0};
		tests[6]  = '{p_data, op_read, 32'h0a4, 32'h0, 32'h0, 4'h0, 0, no_addr, 1'b0};
		tests[7]  = '{p_data, op_write, 32'h0c8, 32'h0, 32'h5a000000, 4'h8, 0, no_addr, 1'b0};
		tests[8]  = '{p_data, op_read, 32'h0c8, 32'h0, 32'h0, 4'h0, 0, no_addr, 1'b0};
		// another tag on the same index sends the dirty victim out first
		tests[9]  = '{p_data, op_read, 32'h1a0, 32'h0, 32'h0, 4'h0, 0, 32'h0a0, 1'b1};
		tests[10] = '{p_data, op_read, 32'h0a4, 32'h0, 32'h0, 4'h0, 0, 32'h0a0, 1'b0};
		// simultaneous misses where the data side is served first
		tests[11] = '{p_both, op_read, 32'h2e0, 32'h300, 32'h0, 4'h0, 0, 32'h2e0, 1'b0};
		tests[12] = '{p_data, op_write, 32'h3c8, 32'h0, 32'h0000beef, 4'h3, 0, 32'h0c0, 1'b1};
		tests[13] = '{p_data, op_read, 32'h3c8, 32'h0, 32'h0, 4'h0, 0, no_addr, 1'b0};
		tests[14] = '{p_instr, op_read, 32'h2e4, 32'h0, 32'h0, 4'h0, 2, no_addr, 1'b0};
		tests[15] = '{p_both, op_read, 32'h0c8, 32'h104, 32'h0, 4'h0, 0, 32'h3c0, 1'b1};

		repeat (8) @(posedge clk);
		#1;
		i_reset = 1'b0;

		// quiet outputs before the first request
		repeat (3) begin
			@(posedge clk);
			#1;
			check_bit("o_pmem_read", o_pmem_read, 1'b0);
			check_bit("o_pmem_write", o_pmem_write, 1'b0);
			check_bit("o_instr_resp", o_instr_resp, 1'b0);
			check_bit("o_data_resp", o_data_resp, 1'b0);
		end

		for (int t = 0; t < n_tests; t++) begin
			run_entry(tests[t]);
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : cache_sys_tb

/* source/cache_sys.sv */
`timescale 1ns/1ps

module cache_sys
	import rv32i_types_pkg::*;
(
	input  logic       clk,
	input  logic       i_reset,

	// physical memory
	input  burst_t     i_pmem_rdata,
	input  logic       i_pmem_resp,
	output logic       o_pmem_read,
	output logic       o_pmem_write,
	output rv32i_word  o_pmem_address,
	output burst_t     o_pmem_wdata,

	// instruction fetch
	input  logic       i_instr_read,
	input  rv32i_word  i_instr_mem_address,
	input  logic       i_if_id_reg_load,
	output rv32i_word  o_instr_mem_rdata,
	output logic       o_instr_resp,

	// data access
	input  logic       i_data_read,
	input  logic       i_data_write,
	input  rv32i_word  i_data_mem_address,
	input  logic [3:0] i_data_mbe,
	input  rv32i_word  i_data_mem_wdata,
	output rv32i_word  o_data_mem_rdata,
	output logic       o_data_resp
);

	// caches to arbiter, arbiter to adaptor
	line_mem_if i_line ();
	line_mem_if d_line ();
	line_mem_if a_line ();

	i_cache i_cache (
		.clk              (clk),
		.i_reset          (i_reset),
		.i_read           (i_instr_read),
		.i_address        (i_instr_mem_address),
		.i_if_id_reg_load (i_if_id_reg_load),
		.o_rdata          (o_instr_mem_rdata),
		.o_resp           (o_instr_resp),
		.mem              (i_line.cache)
	);

	d_cache d_cache (
		.clk       (clk),
		.i_reset   (i_reset),
		.i_read    (i_data_read),
		.i_write   (i_data_write),
		.i_address (i_data_mem_address),
		.i_mbe     (i_data_mbe),
		.i_wdata   (i_data_mem_wdata),
		.o_rdata   (o_data_mem_rdata),
		.o_resp    (o_data_resp),
		.mem       (d_line.cache)
	);

	arbiter arbiter (
		.clk     (clk),
		.i_reset (i_reset),
		.icache  (i_line.mem),
		.dcache  (d_line.mem),
		.mem     (a_line.cache)
	);

	cacheline_adaptor cacheline_adaptor (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_pmem_rdata   (i_pmem_rdata),
		.i_pmem_resp    (i_pmem_resp),
		.o_pmem_read    (o_pmem_read),
		.o_pmem_write   (o_pmem_write),
		.o_pmem_address (o_pmem_address),
		.o_pmem_wdata   (o_pmem_wdata),
		.line           (a_line.mem)
	);

endmodule : cache_sys

/* source/cacheline_adaptor.sv */
`timescale 1ns/1ps

module cacheline_adaptor
	import rv32i_types_pkg::*;
(
	input  logic      clk,
	input  logic      i_reset,
	input  burst_t    i_pmem_rdata,
	input  logic      i_pmem_resp,
	output logic      o_pmem_read,
	output logic      o_pmem_write,
	output rv32i_word o_pmem_address,
	output burst_t    o_pmem_wdata,
	line_mem_if.mem   line
);

	line_t                              line_buf;
	logic [$clog2(bursts_per_line)-1:0] beat;
	logic                               busy;
	logic                               start;
	logic                               resp_q;

	assign busy = o_pmem_read || o_pmem_write;

	// the request is still up during its resp cycle, don't restart on it
	assign start = (line.read || line.write) && !busy && !resp_q;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_pmem_read  <= 1'b0;
			o_pmem_write <= 1'b0;
			beat         <= '0;
			resp_q       <= 1'b0;
		end else begin
			resp_q <= 1'b0;
			if (start) begin
				o_pmem_read  <= line.read;
				o_pmem_write <= line.write;
				beat         <= '0;
			end else if (busy && i_pmem_resp) begin
				beat <= beat + 1'b1;
				// last beat, answer the line side next cycle
				if (&beat) begin
					o_pmem_read  <= 1'b0;
					o_pmem_write <= 1'b0;
					resp_q       <= 1'b1;
				end
			end
		end
	end

	// one shift register serves both directions
	// reads fill from the top, writes drain from the bottom, low beat first
	always_ff @(posedge clk) begin
		if (start) begin
			line_buf       <= line.wdata;
			o_pmem_address <= {line.address[31:offset_bits], {offset_bits{1'b0}}};
		end else if (busy && i_pmem_resp) begin
			line_buf <= {i_pmem_rdata, line_buf[$bits(line_t)-1:$bits(burst_t)]};
		end
	end

	assign o_pmem_wdata = line_buf[$bits(burst_t)-1:0];
	assign line.rdata   = line_buf;
	assign line.resp    = resp_q;

endmodule : cacheline_adaptor

/* arbiter/arbiter.sv */
`timescale 1ns/1ps

module arbiter
	import rv32i_types_pkg::*;
(
	input  logic      clk,
	input  logic      i_reset,
	line_mem_if.mem   icache,
	line_mem_if.mem   dcache,
	line_mem_if.cache mem
);

	arb_state_e state;
	arb_state_e next_state;
	logic       d_req;
	logic       i_req;

	assign d_req = dcache.read || dcache.write;
	assign i_req = icache.read;

	always_comb begin
		next_state = state;
		case (state)
			arb_idle: begin
				// data side wins a tie
				if (d_req) begin
					next_state = serve_d;
				end else if (i_req) begin
					next_state = serve_i;
				end
			end
			serve_i, serve_d: begin
				// one idle cycle after every transfer
				if (mem.resp) begin
					next_state = arb_idle;
				end
			end
			default: next_state = arb_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= arb_idle;
		end else begin
			state <= next_state;
		end
	end

	// request steering, nothing goes out while idle
	always_comb begin
		mem.read    = 1'b0;
		mem.write   = 1'b0;
		mem.address = dcache.address;
		mem.wdata   = dcache.wdata;
		if (state == serve_d) begin
			mem.read  = dcache.read;
			mem.write = dcache.write;
		end else if (state == serve_i) begin
			mem.read    = icache.read;
			mem.write   = icache.write;
			mem.address = icache.address;
			mem.wdata   = icache.wdata;
		end
	end

	// rdata is shared, only the granted side sees resp
	assign icache.rdata = mem.rdata;
	assign dcache.rdata = mem.rdata;
	assign icache.resp  = (state == serve_i) && mem.resp;
	assign dcache.resp  = (state == serve_d) && mem.resp;

endmodule : arbiter

/* cache/d_cache.sv */
`timescale 1ns/1ps

module d_cache
	import rv32i_types_pkg::*;
(
	input  logic       clk,
	input  logic       i_reset,
	input  logic       i_read,
	input  logic       i_write,
	input  rv32i_word  i_address,
	input  logic [3:0] i_mbe,
	input  rv32i_word  i_wdata,
	output rv32i_word  o_rdata,
	output logic       o_resp,
	line_mem_if.cache  mem
);

	line_t                  data_array [num_sets];
	tag_t                   tag_array [num_sets];
	logic [num_sets-1:0]    valid;
	logic [num_sets-1:0]    dirty;
	cache_state_e           state;
	tag_t                   tag;
	index_t                 idx;
	logic [offset_bits-3:0] word_sel;
	logic                   hit;
	logic                   lookup;
	rv32i_word              cur_word;
	rv32i_word              merged;

	assign tag      = i_address[offset_bits + index_bits +: tag_bits];
	assign idx      = i_address[offset_bits +: index_bits];
	assign word_sel = i_address[offset_bits-1:2];
	assign hit      = valid[idx] && (tag_array[idx] == tag);
	assign cur_word = data_array[idx][{word_sel, 5'b0} +: 32];

	// the cycle of resp still shows the old request, skip it
	assign lookup = (state == cache_idle) && (i_read || i_write) && !o_resp;

	// byte-enable merge of the store data into the stored word
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			merged[b*8 +: 8] = i_mbe[b] ? i_wdata[b*8 +: 8] : cur_word[b*8 +: 8];
		end
	end

	assign mem.read  = (state == fill);
	assign mem.write = (state == write_back);
	assign mem.wdata = data_array[idx];

	// victim goes back to where it came from, fills use the cpu address
	assign mem.address = (state == write_back) ?
		{tag_array[idx], idx, {offset_bits{1'b0}}} :
		{i_address[31:offset_bits], {offset_bits{1'b0}}};

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state  <= cache_idle;
			o_resp <= 1'b0;
			valid  <= '0;
			dirty  <= '0;
		end else begin
			o_resp <= 1'b0;
			case (state)
				cache_idle: begin
					if (lookup) begin
						if (hit) begin
							o_resp <= 1'b1;
							if (i_write) begin
								dirty[idx] <= 1'b1;
							end
						end else if (valid[idx] && dirty[idx]) begin
							state <= write_back;
						end else begin
							state <= fill;
						end
					end
				end
				write_back: begin
					if (mem.resp) begin
						state <= fill;
					end
				end
				fill: begin
					// write miss merges on the hit that follows the fill
					if (mem.resp) begin
						valid[idx] <= 1'b1;
						dirty[idx] <= 1'b0;
						state      <= cache_idle;
					end
				end
				default: state <= cache_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (lookup && hit) begin
			if (i_write) begin
				data_array[idx][{word_sel, 5'b0} +: 32] <= merged;
			end else begin
				o_rdata <= cur_word;
			end
		end
		if ((state == fill) && mem.resp) begin
			data_array[idx] <= mem.rdata;
			tag_array[idx]  <= tag;
		end
	end

endmodule : d_cache

/* cache/i_cache.sv */
`timescale 1ns/1ps

module i_cache
	import rv32i_types_pkg::*;
(
	input  logic      clk,
	input  logic      i_reset,
	input  logic      i_read,
	input  rv32i_word i_address,
	input  logic      i_if_id_reg_load,
	output rv32i_word o_rdata,
	output logic      o_resp,
	line_mem_if.cache mem
);

	line_t                  data_array [num_sets];
	tag_t                   tag_array [num_sets];
	logic [num_sets-1:0]    valid;
	cache_state_e           state;
	logic                   hold;
	tag_t                   tag;
	index_t                 idx;
	logic [offset_bits-3:0] word_sel;
	logic                   hit;
	logic                   lookup;

	assign tag      = i_address[offset_bits + index_bits +: tag_bits];
	assign idx      = i_address[offset_bits +: index_bits];
	assign word_sel = i_address[offset_bits-1:2];
	assign hit      = valid[idx] && (tag_array[idx] == tag);

	// a fetch already answered, or parked behind a stalled IF/ID, is not looked up again
	assign lookup = (state == cache_idle) && i_read && !o_resp && !hold;

	// read-only, the line port never writes
	assign mem.read    = (state == fill);
	assign mem.write   = 1'b0;
	assign mem.address = {i_address[31:offset_bits], {offset_bits{1'b0}}};
	assign mem.wdata   = '0;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state  <= cache_idle;
			o_resp <= 1'b0;
			hold   <= 1'b0;
			valid  <= '0;
		end else begin
			o_resp <= 1'b0;
			case (state)
				cache_idle: begin
					if (lookup) begin
						if (hit) begin
							o_resp <= 1'b1;
						end else begin
							state <= fill;
						end
					end
				end
				fill: begin
					// line lands this edge, compare again in idle next cycle
					if (mem.resp) begin
						valid[idx] <= 1'b1;
						state      <= cache_idle;
					end
				end
				default: state <= cache_idle;
			endcase

			// keep the answered fetch blocked until the pipeline takes it
			if (i_if_id_reg_load) begin
				hold <= 1'b0;
			end else if (o_resp) begin
				hold <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		// o_rdata only moves on a new hit, so a stall sees the same word
		if (lookup && hit) begin
			o_rdata <= data_array[idx][{word_sel, 5'b0} +: 32];
		end
		if ((state == fill) && mem.resp) begin
			data_array[idx] <= mem.rdata;
			tag_array[idx]  <= tag;
		end
	end

endmodule : i_cache

/* common/line_mem_if.sv */
`timescale 1ns/1ps

interface line_mem_if
	import rv32i_types_pkg::*;
();

	// request side, held until resp
	logic      read;
	logic      write;
	rv32i_word address;
	line_t     wdata;

	// response side, resp pulses for one cycle
	line_t     rdata;
	logic      resp;

	modport cache (
		output read, write, address, wdata,
		input  rdata, resp
	);

	modport mem (
		input  read, write, address, wdata,
		output rdata, resp
	);

endinterface : line_mem_if

/* common/rv32i_types_pkg.sv */
package rv32i_types_pkg;

	// cache geometry: 32-byte lines, 8 sets, direct mapped
	localparam int offset_bits     = 5;
	localparam int index_bits      = 3;
	localparam int tag_bits        = 32 - index_bits - offset_bits;
	localparam int num_sets        = 2 ** index_bits;
	localparam int bursts_per_line = 4;

	// cpu word and address
	typedef logic [31:0] rv32i_word;

	// one full cache line, eight words
	typedef logic [(2 ** offset_bits) * 8 - 1:0] line_t;

	// one beat on the physical memory bus
	typedef logic [$bits(line_t) / bursts_per_line - 1:0] burst_t;

	typedef logic [index_bits-1:0] index_t;
	typedef logic [tag_bits-1:0]   tag_t;

	// which cache owns the line port
	typedef enum logic [1:0] {
		arb_idle,
		serve_i,
		serve_d
	} arb_state_e;

	// shared by both caches, the icache never enters write_back
	typedef enum logic [1:0] {
		cache_idle,
		write_back,
		fill
	} cache_state_e;

endpackage : rv32i_types_pkg
